/* Bender.yml */
package:
  name: sad_match

sources:
  - rtl/sadPkg.sv
  - rtl/sadBusSlave.sv
  - rtl/pixelStore.sv
  - rtl/absDiffStage.sv
  - rtl/sadAdderTree.sv
  - rtl/minTracker.sv
  - rtl/sadTop.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/sadTb.sv

/* compile.f */
+incdir+tests
rtl/sadPkg.sv
rtl/sadBusSlave.sv
rtl/pixelStore.sv
rtl/absDiffStage.sv
rtl/sadAdderTree.sv
rtl/minTracker.sv
rtl/sadTop.sv
tests/sadTb.sv

/* rtl/absDiffStage.sv */
`timescale 1ns/1ps

module absDiffStage import sadPkg::*; (
    input  logic                      Clk,
    input  logic                      rstN,
    input  logic                      fetchValid,
    input  pixelT   [BlockPixels-1:0] candPixels,
    input  pixelT   [BlockPixels-1:0] blockPixels,
    input  coordT                     fetchRow,
    input  coordT                     fetchCol,
    output logic                      diffValid,
    output absDiffT [BlockPixels-1:0] diffs,
    output coordT                     diffRow,
    output coordT                     diffCol
);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            diffValid <= 1'b0;
        end else begin
            diffValid <= fetchValid;
        end
    end

    // Unsigned |a - b|, subtract the smaller from the larger
    always_ff @(posedge Clk) begin
        if (fetchValid) begin
            for (int i = 0; i < BlockPixels; i++) begin
                if (candPixels[i] > blockPixels[i]) begin
                    diffs[i] <= candPixels[i] - blockPixels[i];
                end else begin
                    diffs[i] <= blockPixels[i] - candPixels[i];
                end
            end
            diffRow <= fetchRow;
            diffCol <= fetchCol;
        end
    end

endmodule

/* rtl/minTracker.sv */
`timescale 1ns/1ps

module minTracker import sadPkg::*; (
    input  logic  Clk,
    input  logic  rstN,
    input  logic  sadValid,
    input  sadT   sad,
    input  coordT sadRow,
    input  coordT sadCol,
    input  logic  clearBest,
    output sadT   minSad,
    output coordT bestRow,
    output coordT bestCol
);

    logic better;

    // Strictly smaller only, so the first of equal minima stays
    assign better = sadValid && (sad < minSad);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            minSad  <= SadInit;
            bestRow <= '0;
            bestCol <= '0;
        end else if (clearBest) begin
            // Clear takes priority over a result arriving the same cycle
            minSad  <= SadInit;
            bestRow <= '0;
            bestCol <= '0;
        end else if (better) begin
            minSad  <= sad;
            bestRow <= sadRow;
            bestCol <= sadCol;
        end
    end

endmodule

/* rtl/pixelStore.sv */
`timescale 1ns/1ps

module pixelStore import sadPkg::*; (
    input  logic                    Clk,
    input  logic                    rstN,
    input  logic                    frameWe,
    input  logic                    blockWe,
    input  frameIdxT                pixelIdx,
    input  pixelT                   pixelData,
    input  logic                    launch,
    input  coordT                   candRow,
    input  coordT                   candCol,
    output logic                    fetchValid,
    output pixelT [BlockPixels-1:0] candPixels,
    output pixelT [BlockPixels-1:0] blockPixels,
    output coordT                   fetchRow,
    output coordT                   fetchCol
);

    pixelT    frame [FrameDim*FrameDim];
    pixelT    block [BlockPixels];
    frameIdxT fetchIdx [BlockPixels];

    // Search area and reference block
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < FrameDim * FrameDim; i++) begin
                frame[i] <= '0;
            end
            for (int i = 0; i < BlockPixels; i++) begin
                block[i] <= '0;
            end
        end else begin
            if (frameWe) begin
                frame[pixelIdx] <= pixelData;
            end
            // Block index lives in the low nibble
            if (blockWe) begin
                block[pixelIdx[3:0]] <= pixelData;
            end
        end
    end

    // Area index of each block pixel, row stride is the area width
    always_comb begin
        for (int r = 0; r < BlockDim; r++) begin
            for (int c = 0; c < BlockDim; c++) begin
                fetchIdx[r*BlockDim + c] =
                    frameIdxT'((int'(candRow) + r) * FrameDim + int'(candCol) + c);
            end
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= launch;
        end
    end

    // Sixteen parallel reads plus the block, captured together
    always_ff @(posedge Clk) begin
        if (launch) begin
            for (int i = 0; i < BlockPixels; i++) begin
                candPixels[i]  <= frame[fetchIdx[i]];
                blockPixels[i] <= block[i];
            end
            fetchRow <= candRow;
            fetchCol <= candCol;
        end
    end

endmodule

/* rtl/sadAdderTree.sv */
`timescale 1ns/1ps

module sadAdderTree import sadPkg::*; (
    input  logic                      Clk,
    input  logic                      rstN,
    input  logic                      diffValid,
    input  absDiffT [BlockPixels-1:0] diffs,
    input  coordT                     diffRow,
    input  coordT                     diffCol,
    output logic                      partValid,
    output logic                      sadValid,
    output sadT                       sad,
    output coordT                     sadRow,
    output coordT                     sadCol
);

    sadT   rowSum [BlockDim];
    sadT   partSum [BlockDim];
    sadT   total;
    coordT partRow;
    coordT partCol;

    // One partial sum per block row
    always_comb begin
        for (int r = 0; r < BlockDim; r++) begin
            rowSum[r] = '0;
            for (int c = 0; c < BlockDim; c++) begin
                rowSum[r] = rowSum[r] + sadT'(diffs[r*BlockDim + c]);
            end
        end
    end

    always_comb begin
        total = '0;
        for (int r = 0; r < BlockDim; r++) begin
            total = total + partSum[r];
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            partValid <= 1'b0;
            sadValid  <= 1'b0;
        end else begin
            partValid <= diffValid;
            sadValid  <= partValid;
        end
    end

    always_ff @(posedge Clk) begin
        if (diffValid) begin
            partSum <= rowSum;
            partRow <= diffRow;
            partCol <= diffCol;
        end
        if (partValid) begin
            sad    <= total;
            sadRow <= partRow;
            sadCol <= partCol;
        end
    end

endmodule

/* rtl/sadBusSlave.sv */
`timescale 1ns/1ps

module sadBusSlave import sadPkg::*; (
    input  logic     Clk,
    input  logic     rstN,
    input  logic     wbCyc,
    input  logic     wbStb,
    input  logic     wbWe,
    input  wbAdrT    wbAdr,
    input  wbDataT   wbDatW,
    input  logic     busy,
    input  sadT      minSad,
    input  coordT    bestRow,
    input  coordT    bestCol,
    output wbDataT   wbDatR,
    output logic     wbAck,
    output logic     frameWe,
    output logic     blockWe,
    output frameIdxT pixelIdx,
    output pixelT    pixelData,
    output logic     launch,
    output coordT    candRow,
    output coordT    candCol,
    output logic     clearBest
);

    logic   accept;
    logic   frameHit;
    logic   blockHit;
    logic   cmdHit;
    logic   cmdLegal;
    coordT  cmdRow;
    coordT  cmdCol;
    wbDataT rdData;

    // A new access is taken on the first edge with strobe high and no ack pending
    assign accept = wbCyc && wbStb && !wbAck;

    // Frame uses 0x000-0x0FF, block uses 0x100-0x10F
    assign frameHit = (wbAdr[9:8] == AdrFrameBase[9:8]);
    assign blockHit = (wbAdr[9:4] == AdrBlockBase[9:4]);
    assign cmdHit   = (wbAdr == AdrCommand);

    assign cmdRow   = wbDatW[CoordRowLsb +: $bits(coordT)];
    assign cmdCol   = wbDatW[CoordColLsb +: $bits(coordT)];
    assign cmdLegal = (cmdRow <= MaxCoord) && (cmdCol <= MaxCoord);

    // Pixel writes land in the store on the ack edge
    assign frameWe   = accept && wbWe && frameHit;
    assign blockWe   = accept && wbWe && blockHit;
    assign pixelIdx  = wbAdr[7:0];
    assign pixelData = wbDatW[7:0];

    // Read map; pixel arrays and holes read as zero
    always_comb begin
        rdData = '0;
        case (wbAdr)
            AdrStatus:  rdData[0] = busy;
            AdrMinSad:  rdData = wbDataT'(minSad);
            AdrBestPos: begin
                rdData[CoordRowLsb +: $bits(coordT)] = bestRow;
                rdData[CoordColLsb +: $bits(coordT)] = bestCol;
            end
            default:    rdData = '0;
        endcase
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            wbAck     <= 1'b0;
            wbDatR    <= '0;
            launch    <= 1'b0;
            clearBest <= 1'b0;
        end else begin
            wbAck     <= accept;
            wbDatR    <= (accept && !wbWe) ? rdData : '0;
            // Out-of-range commands are acked but never launched
            launch    <= accept && wbWe && cmdHit && cmdLegal;
            clearBest <= accept && wbWe && (wbAdr == AdrClear);
        end
    end

    // Candidate corner is qualified by launch downstream
    always_ff @(posedge Clk) begin
        if (accept && wbWe && cmdHit) begin
            candRow <= cmdRow;
            candCol <= cmdCol;
        end
    end

endmodule

/* rtl/sadPkg.sv */
package sadPkg;

    // Data widths
    typedef logic [7:0]  pixelT;
    typedef logic [7:0]  absDiffT;
    // Sixteen differences of at most 255 each
    typedef logic [11:0] sadT;
    typedef logic [3:0]  coordT;
    // Row times 16 plus column
    typedef logic [7:0]  frameIdxT;

    typedef logic [9:0]  wbAdrT;
    typedef logic [31:0] wbDataT;

    // Search area and block geometry
    localparam int FrameDim    = 16;
    localparam int BlockDim    = 4;
    localparam int BlockPixels = BlockDim * BlockDim;
    // Largest top-left corner that keeps the block inside the area
    localparam int MaxCoord    = FrameDim - BlockDim;

    // Best-match register value after reset or clear
    localparam sadT SadInit = '1;

    // Word address map
    localparam wbAdrT AdrFrameBase = 10'h000;
    localparam wbAdrT AdrBlockBase = 10'h100;
    localparam wbAdrT AdrCommand   = 10'h200;
    localparam wbAdrT AdrClear     = 10'h201;
    localparam wbAdrT AdrStatus    = 10'h202;
    localparam wbAdrT AdrMinSad    = 10'h203;
    localparam wbAdrT AdrBestPos   = 10'h204;

    // Coordinate fields of the command and best-position words
    localparam int CoordColLsb = 0;
    localparam int CoordRowLsb = 4;

endpackage

/* rtl/sadTop.sv */
`timescale 1ns/1ps

module sadTop import sadPkg::*; (
    input  logic   Clk,
    input  logic   rstN,
    input  logic   wbCyc,
    input  logic   wbStb,
    input  logic   wbWe,
    input  wbAdrT  wbAdr,
    input  wbDataT wbDatW,
    output wbDataT wbDatR,
    output logic   wbAck
);

    // Bus side
    logic     frameWe;
    logic     blockWe;
    frameIdxT pixelIdx;
    pixelT    pixelData;
    logic     launch;
    coordT    candRow;
    coordT    candCol;
    logic     clearBest;
    logic     busy;

    // Pipeline
    logic                      fetchValid;
    pixelT   [BlockPixels-1:0] candPixels;
    pixelT   [BlockPixels-1:0] blockPixels;
    coordT                     fetchRow;
    coordT                     fetchCol;
    logic                      diffValid;
    absDiffT [BlockPixels-1:0] diffs;
    coordT                     diffRow;
    coordT                     diffCol;
    logic                      partValid;
    logic                      sadValid;
    sadT                       sad;
    coordT                     sadRow;
    coordT                     sadCol;

    // Results
    sadT   minSad;
    coordT bestRow;
    coordT bestCol;

    // High while any candidate is anywhere between launch and the min register
    assign busy = launch | fetchValid | diffValid | partValid | sadValid;

    sadBusSlave i_busSlave (
        .Clk       (Clk),
        .rstN      (rstN),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .busy      (busy),
        .minSad    (minSad),
        .bestRow   (bestRow),
        .bestCol   (bestCol),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .frameWe   (frameWe),
        .blockWe   (blockWe),
        .pixelIdx  (pixelIdx),
        .pixelData (pixelData),
        .launch    (launch),
        .candRow   (candRow),
        .candCol   (candCol),
        .clearBest (clearBest)
    );

    pixelStore i_pixelStore (
        .Clk         (Clk),
        .rstN        (rstN),
        .frameWe     (frameWe),
        .blockWe     (blockWe),
        .pixelIdx    (pixelIdx),
        .pixelData   (pixelData),
        .launch      (launch),
        .candRow     (candRow),
        .candCol     (candCol),
        .fetchValid  (fetchValid),
        .candPixels  (candPixels),
        .blockPixels (blockPixels),
        .fetchRow    (fetchRow),
        .fetchCol    (fetchCol)
    );

    absDiffStage i_absDiff (
        .Clk         (Clk),
        .rstN        (rstN),
        .fetchValid  (fetchValid),
        .candPixels  (candPixels),
        .blockPixels (blockPixels),
        .fetchRow    (fetchRow),
        .fetchCol    (fetchCol),
        .diffValid   (diffValid),
        .diffs       (diffs),
        .diffRow     (diffRow),
        .diffCol     (diffCol)
    );

    sadAdderTree i_adderTree (
        .Clk       (Clk),
        .rstN      (rstN),
        .diffValid (diffValid),
        .diffs     (diffs),
        .diffRow   (diffRow),
        .diffCol   (diffCol),
        .partValid (partValid),
        .sadValid  (sadValid),
        .sad       (sad),
        .sadRow    (sadRow),
        .sadCol    (sadCol)
    );

    minTracker i_minTracker (
        .Clk       (Clk),
        .rstN      (rstN),
        .sadValid  (sadValid),
        .sad       (sad),
        .sadRow    (sadRow),
        .sadCol    (sadCol),
        .clearBest (clearBest),
        .minSad    (minSad),
        .bestRow   (bestRow),
        .bestCol   (bestCol)
    );

endmodule

/* tests/sadModel.svh */
`ifndef SAD_MODEL_SVH
`define SAD_MODEL_SVH

// Reference copies of the search area and the block
pixelT modelFrame [FrameDim*FrameDim];
pixelT modelBlock [BlockPixels];

// Best match so far, strict-less rule
int modelMinSad;
int modelBestRow;
int modelBestCol;

logic [31:0] lcgState;

// Numerical Recipes LCG constants
function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
endfunction

// Sum of absolute differences over the window with its top-left corner at (row, col)
function automatic int blockSad(input int row, input int col);
    int sum;
    int a;
    int b;
    sum = 0;
    for (int r = 0; r < BlockDim; r++) begin
        for (int c = 0; c < BlockDim; c++) begin
            a = modelFrame[(row + r) * FrameDim + col + c];
            b = modelBlock[r * BlockDim + c];
            sum += (a > b) ? a - b : b - a;
        end
    end
    return sum;
endfunction

function automatic void trackBest(input int row, input int col);
    int s;
    s = blockSad(row, col);
    // Earlier candidate keeps a tie
    if (s < modelMinSad) begin
        modelMinSad  = s;
        modelBestRow = row;
        modelBestCol = col;
    end
endfunction

function automatic void resetBest();
    modelMinSad  = 4095;
    modelBestRow = 0;
    modelBestCol = 0;
endfunction

`endif

/* tests/sadTb.sv */
`timescale 1ns/1ps

module sadTb import sadPkg::*; ();

    localparam int AckTimeout   = 16;
    localparam int IdleTimeout  = 64;
    localparam int SeriesLength = 12;

    logic   Clk;
    logic   rstN;
    logic   wbCyc;
    logic   wbStb;
    logic   wbWe;
    wbAdrT  wbAdr;
    wbDataT wbDatW;
    wbDataT wbDatR;
    logic   wbAck;

    int errorCount;
    int timeoutCount;

    `include "sadModel.svh"

    sadTop i_dut (
        .Clk    (Clk),
        .rstN   (rstN),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck)
    );

    always #4 Clk = ~Clk;

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        assert (got === exp) else begin
            errorCount++;
            $display("error at time %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
        end
    endtask

    // Command and best-position layout
    function automatic wbDataT positionWord(input int row, input int col);
        return wbDataT'((row << CoordRowLsb) | (col << CoordColLsb));
    endfunction

    // One classic access entered right after a rising edge
    task automatic access(input logic write, input wbAdrT adr, input wbDataT data,
                          output wbDataT rdata);
        int edges;
        wbCyc  <= 1'b1;
        wbStb  <= 1'b1;
        wbWe   <= write;
        wbAdr  <= adr;
        wbDatW <= data;
        edges  = 0;
        rdata  = '0;
        do begin
            @(posedge Clk);
            edges++;
        end while (!wbAck && edges < AckTimeout);
        if (!wbAck) begin
            timeoutCount++;
            $display("timeout: no acknowledge for the access to address 0x%0h", adr);
        end else begin
            // Strobe is taken on the first edge, ack is seen on the next
            checkValue("wbAck latency", edges, 2);
            rdata = wbDatR;
        end
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe  <= 1'b0;
        @(posedge Clk);
        checkValue("wbAck", wbAck, 0);
    endtask

    task automatic writeWord(input wbAdrT adr, input wbDataT data);
        wbDataT unused;
        access(1'b1, adr, data, unused);
    endtask

    task automatic expectRead(input string name, input wbAdrT adr, input wbDataT exp);
        wbDataT data;
        access(1'b0, adr, '0, data);
        checkValue(name, data, exp);
    endtask

    task automatic waitIdle();
        wbDataT status;
        int polls;
        polls = 0;
        do begin
            access(1'b0, AdrStatus, '0, status);
            polls++;
        end while (status[0] && polls < IdleTimeout);
        if (status[0]) begin
            timeoutCount++;
            $display("timeout: the block matcher stayed busy");
        end
    endtask

    task automatic loadRandomPixels();
        for (int i = 0; i < FrameDim * FrameDim; i++) begin
            modelFrame[i] = pixelT'(nextRandom() >> 24);
            writeWord(wbAdrT'(AdrFrameBase + i), wbDataT'(modelFrame[i]));
        end
        for (int i = 0; i < BlockPixels; i++) begin
            modelBlock[i] = pixelT'(nextRandom() >> 24);
            writeWord(wbAdrT'(AdrBlockBase + i), wbDataT'(modelBlock[i]));
        end
    endtask

    // Commands go out back to back, so several candidates overlap
    task automatic launchSeries(input int count);
        int row;
        int col;
        for (int n = 0; n < count; n++) begin
            row = (nextRandom() >> 16) % (MaxCoord + 1);
            col = (nextRandom() >> 16) % (MaxCoord + 1);
            trackBest(row, col);
            writeWord(AdrCommand, positionWord(row, col));
        end
    endtask

    task automatic expectResults();
        expectRead("minSad", AdrMinSad, wbDataT'(modelMinSad));
        expectRead("bestPos", AdrBestPos, positionWord(modelBestRow, modelBestCol));
    endtask

    // Block becomes an exact copy of the area at (row, col)
    task automatic matchCopiedBlock(input int row, input int col);
        int idx;
        waitIdle();
        for (int r = 0; r < BlockDim; r++) begin
            for (int c = 0; c < BlockDim; c++) begin
                idx = r * BlockDim + c;
                modelBlock[idx] = modelFrame[(row + r) * FrameDim + col + c];
                writeWord(wbAdrT'(AdrBlockBase + idx), wbDataT'(modelBlock[idx]));
            end
        end
        writeWord(AdrClear, '0);
        resetBest();
        writeWord(AdrCommand, positionWord(row, col));
        trackBest(row, col);
        waitIdle();
        expectRead("minSad", AdrMinSad, 0);
        expectRead("bestPos", AdrBestPos, positionWord(row, col));
    endtask

    initial begin
        wbDataT savedSad;
        wbDataT savedPos;
        Clk          = 1'b0;
        rstN         = 1'b0;
        wbCyc        = 1'b0;
        wbStb        = 1'b0;
        wbWe         = 1'b0;
        wbAdr        = '0;
        wbDatW       = '0;
        errorCount   = 0;
        timeoutCount = 0;
        lcgState     = 32'he9a6_9f4e;
        resetBest();
        repeat (3) @(posedge Clk);
        rstN <= 1'b1;
        @(posedge Clk);

        // Register map right after reset
        expectRead("minSad", AdrMinSad, 32'd4095);
        expectRead("bestPos", AdrBestPos, 0);
        expectRead("status", AdrStatus, 0);
        expectRead("frame pixel", wbAdrT'(AdrFrameBase + 8'h37), 0);
        expectRead("block pixel", wbAdrT'(AdrBlockBase + 4'h5), 0);
        expectRead("unmapped", 10'h205, 0);
        expectRead("unmapped", 10'h3ff, 0);

        loadRandomPixels();
        launchSeries(SeriesLength);
        waitIdle();
        expectResults();
        expectRead("frame pixel", wbAdrT'(AdrFrameBase + 8'h37), 0);
        expectRead("block pixel", wbAdrT'(AdrBlockBase + 4'h5), 0);

        // Out-of-range corners are acked and dropped
        access(1'b0, AdrMinSad, '0, savedSad);
        access(1'b0, AdrBestPos, '0, savedPos);
        writeWord(AdrCommand, positionWord(13 + nextRandom() % 3, nextRandom() % 13));
        expectRead("status", AdrStatus, 0);
        writeWord(AdrCommand, positionWord(nextRandom() % 13, 13 + nextRandom() % 3));
        writeWord(AdrCommand, positionWord(15, 15));
        expectRead("status", AdrStatus, 0);
        expectRead("minSad", AdrMinSad, savedSad);
        expectRead("bestPos", AdrBestPos, savedPos);

        matchCopiedBlock(nextRandom() % 13, nextRandom() % 13);
        matchCopiedBlock(MaxCoord, MaxCoord);

        // Clear while idle, then a fresh series
        waitIdle();
        writeWord(AdrClear, '0);
        resetBest();
        expectRead("minSad", AdrMinSad, 32'd4095);
        expectRead("bestPos", AdrBestPos, 0);
        loadRandomPixels();
        launchSeries(SeriesLength);
        waitIdle();
        expectResults();

        $display("checks done: %0d errors, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
